// File: compile.f
+incdir+rtl
rtl/l2_pkg.sv
rtl/l2_regs_if.sv
rtl/l2_regs.sv
rtl/l2_reqs_table.sv
rtl/l2_flush_ctrl.sv
rtl/l2_ctrl_top.sv
testbench/tb_clk_gen.sv
testbench/l2_checker.sv
testbench/l2_tb.sv

// File: rtl/l2_ctrl_top.sv
// L2 controller slice top
`timescale 1ns/1ns
`default_nettype none

`include "l2_settings.svh"

module l2_ctrl_top (
    input  wire                       clk,
    input  wire                       rst,
    input  wire                       alloc_i,
    input  wire  [`L2_SET_BITS-1:0]   alloc_set_i,
    input  wire                       free_i,
    input  wire  [`REQS_BITS-1:0]     free_idx_i,
    input  wire                       fwd_i,
    input  wire  [`L2_SET_BITS-1:0]   fwd_set_i,
    input  wire                       flush_i,
    output logic                      alloc_ok_o,
    output logic [`REQS_BITS-1:0]     alloc_idx_o,
    output logic                      alloc_busy_o,
    output logic                      conflict_o,
    output logic                      fwd_stall_o,
    output logic                      fwd_done_o,
    output logic                      ongoing_flush_o,
    output logic [`REQS_BITS_P1-1:0]  reqs_cnt_o,
    output logic                      flush_valid_o,
    output logic [`L2_SET_BITS-1:0]   flush_set_o,
    output logic [`L2_WAY_BITS-1:0]   flush_way_o,
    output logic                      flush_done_o
);

    l2_regs_if regs_if ();

    l2_regs u_regs (
        .clk     (clk),
        .rst     (rst),
        .regs_if (regs_if.regs)
    );

    l2_reqs_table u_reqs_table (
        .clk          (clk),
        .rst          (rst),
        .alloc_i      (alloc_i),
        .alloc_set_i  (alloc_set_i),
        .free_i       (free_i),
        .free_idx_i   (free_idx_i),
        .fwd_i        (fwd_i),
        .fwd_set_i    (fwd_set_i),
        .alloc_ok_o   (alloc_ok_o),
        .alloc_idx_o  (alloc_idx_o),
        .alloc_busy_o (alloc_busy_o),
        .fwd_done_o   (fwd_done_o),
        .regs_if      (regs_if.reqs)
    );

    l2_flush_ctrl u_flush_ctrl (
        .clk           (clk),
        .rst           (rst),
        .flush_i       (flush_i),
        .flush_valid_o (flush_valid_o),
        .flush_done_o  (flush_done_o),
        .regs_if       (regs_if.flush)
    );

    assign conflict_o = regs_if.set_conflict;
    assign fwd_stall_o = regs_if.fwd_stall;
    assign ongoing_flush_o = regs_if.ongoing_flush;
    assign reqs_cnt_o = regs_if.reqs_cnt;
    assign flush_set_o = regs_if.flush_set[`L2_SET_BITS-1:0]; // drop the wrap bit.
    assign flush_way_o = regs_if.flush_way[`L2_WAY_BITS-1:0];

endmodule

`default_nettype wire

// File: rtl/l2_flush_ctrl.sv
// Flush sweeper
`timescale 1ns/1ns
`default_nettype none

`include "l2_settings.svh"

module l2_flush_ctrl (
    input  wire      clk,
    input  wire      rst,
    input  wire      flush_i,
    output logic     flush_valid_o,
    output logic     flush_done_o,
    l2_regs_if.flush regs_if
);

    l2_pkg::flush_way_t way_nxt;
    logic way_wrap, set_top, sweep_q;

    // the set is finished once the stepped way counter reaches its top bit.
    assign way_nxt = regs_if.flush_way + l2_pkg::flush_way_t'(1);
    assign way_wrap = way_nxt[`L2_WAY_BITS];
    assign set_top = regs_if.flush_set[`L2_SET_BITS];

    assign flush_valid_o = sweep_q && !set_top;
    assign flush_done_o = regs_if.ongoing_flush && set_top;

    assign regs_if.set_ongoing_flush = flush_i && !regs_if.ongoing_flush;
    assign regs_if.clr_ongoing_flush = flush_done_o;

    assign regs_if.incr_flush_way = flush_valid_o && !way_wrap;
    assign regs_if.clr_flush_way = flush_done_o || (flush_valid_o && way_wrap);
    assign regs_if.incr_flush_set = flush_valid_o && way_wrap;
    assign regs_if.clr_flush_set = flush_done_o;

    // sweep starts one cycle after the flag rises.
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            sweep_q <= 1'b0;
        end else begin
            sweep_q <= regs_if.ongoing_flush && !set_top;
        end
    end

    a_valid_in_flush: assert property (@(posedge clk) disable iff (!rst)
        flush_valid_o |-> regs_if.ongoing_flush);

endmodule

`default_nettype wire

// File: rtl/l2_pkg.sv
// L2 slice types
`default_nettype none

`include "l2_settings.svh"

package l2_pkg;

    typedef logic [`L2_SET_BITS-1:0] set_t;

    // top bit flags a finished sweep.
    typedef logic [`L2_SET_BITS:0] flush_set_t;

    // top bit flags a finished set.
    typedef logic [`L2_WAY_BITS:0] flush_way_t;

    typedef logic [`REQS_BITS-1:0] reqs_idx_t;
    typedef logic [`REQS_BITS_P1-1:0] reqs_cnt_t;

    typedef struct packed {
        logic valid;
        set_t req_set;
    } req_entry_t;

endpackage

`default_nettype wire

// File: rtl/l2_regs.sv
// L2 status registers
`timescale 1ns/1ns
`default_nettype none

`include "l2_settings.svh"

module l2_regs (
    input wire clk,
    input wire rst,
    l2_regs_if.regs regs_if
);

    localparam l2_pkg::reqs_cnt_t CNT_MAX = l2_pkg::reqs_cnt_t'(`N_REQS);

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            regs_if.ongoing_flush <= 1'b0;
        end else if (regs_if.clr_ongoing_flush) begin
            regs_if.ongoing_flush <= 1'b0;
        end else if (regs_if.set_ongoing_flush) begin
            regs_if.ongoing_flush <= 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            regs_if.flush_set <= '0;
        end else if (regs_if.clr_flush_set) begin
            regs_if.flush_set <= '0;
        end else if (regs_if.incr_flush_set) begin
            regs_if.flush_set <= regs_if.flush_set + l2_pkg::flush_set_t'(1);
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            regs_if.flush_way <= '0;
        end else if (regs_if.clr_flush_way) begin
            regs_if.flush_way <= '0;
        end else if (regs_if.incr_flush_way) begin
            regs_if.flush_way <= regs_if.flush_way + l2_pkg::flush_way_t'(1);
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            regs_if.set_conflict <= 1'b0;
        end else if (regs_if.clr_set_conflict) begin
            regs_if.set_conflict <= 1'b0;
        end else if (regs_if.set_set_conflict) begin
            regs_if.set_conflict <= 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            regs_if.fwd_stall <= 1'b0;
        end else if (regs_if.clr_fwd_stall) begin
            regs_if.fwd_stall <= 1'b0;
        end else if (regs_if.set_fwd_stall) begin
            regs_if.fwd_stall <= 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            regs_if.fwd_stall_i <= '0;
        end else if (regs_if.set_fwd_stall_i) begin
            regs_if.fwd_stall_i <= regs_if.fwd_stall_i_wr_data; // index of the stalled entry.
        end
    end

    // a fill and a free in the same cycle cancel out.
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            regs_if.reqs_cnt <= CNT_MAX;
        end else if (regs_if.fill_reqs != regs_if.incr_reqs_cnt) begin
            if (regs_if.fill_reqs) begin
                regs_if.reqs_cnt <= regs_if.reqs_cnt - l2_pkg::reqs_cnt_t'(1);
            end else begin
                regs_if.reqs_cnt <= regs_if.reqs_cnt + l2_pkg::reqs_cnt_t'(1);
            end
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            regs_if.fwd_stall_ended <= 1'b0;
        end else if (regs_if.clr_fwd_stall_ended) begin
            regs_if.fwd_stall_ended <= 1'b0;
        end else if (regs_if.wr_en_put_reqs && regs_if.fwd_stall &&
                     regs_if.fwd_stall_i == regs_if.reqs_i) begin
            regs_if.fwd_stall_ended <= 1'b1; // stalled entry was just freed.
        end
    end

    a_cnt_max: assert property (@(posedge clk) disable iff (!rst)
        regs_if.reqs_cnt <= CNT_MAX);

    a_fill_nonzero: assert property (@(posedge clk) disable iff (!rst)
        regs_if.fill_reqs |-> regs_if.reqs_cnt != '0);

endmodule

`default_nettype wire

// File: rtl/l2_regs_if.sv
// L2 status register bundle
`timescale 1ns/1ns
`default_nettype none

interface l2_regs_if;

    logic set_ongoing_flush, clr_ongoing_flush, ongoing_flush;
    logic incr_flush_set, clr_flush_set;
    l2_pkg::flush_set_t flush_set;
    logic incr_flush_way, clr_flush_way;
    l2_pkg::flush_way_t flush_way;
    logic set_set_conflict, clr_set_conflict, set_conflict;
    logic set_fwd_stall, clr_fwd_stall, fwd_stall;
    logic set_fwd_stall_i;
    l2_pkg::reqs_idx_t fwd_stall_i_wr_data, fwd_stall_i;
    logic fill_reqs, incr_reqs_cnt;
    l2_pkg::reqs_cnt_t reqs_cnt;
    logic clr_fwd_stall_ended, wr_en_put_reqs, fwd_stall_ended;
    l2_pkg::reqs_idx_t reqs_i;

    modport regs (
        input  set_ongoing_flush, clr_ongoing_flush, incr_flush_set, clr_flush_set,
        input  incr_flush_way, clr_flush_way, set_set_conflict, clr_set_conflict,
        input  set_fwd_stall, clr_fwd_stall, set_fwd_stall_i, fwd_stall_i_wr_data,
        input  fill_reqs, incr_reqs_cnt, clr_fwd_stall_ended, wr_en_put_reqs, reqs_i,
        output ongoing_flush, flush_set, flush_way, set_conflict, fwd_stall,
        output fwd_stall_i, reqs_cnt, fwd_stall_ended
    );

    modport reqs (
        output set_set_conflict, clr_set_conflict, set_fwd_stall, clr_fwd_stall,
        output set_fwd_stall_i, fwd_stall_i_wr_data, fill_reqs, incr_reqs_cnt,
        output wr_en_put_reqs, reqs_i, clr_fwd_stall_ended,
        input  set_conflict, fwd_stall, fwd_stall_i, reqs_cnt, fwd_stall_ended,
        input  ongoing_flush
    );

    modport flush (
        output set_ongoing_flush, clr_ongoing_flush, incr_flush_set, clr_flush_set,
        output incr_flush_way, clr_flush_way,
        input  ongoing_flush, flush_set, flush_way
    );

endinterface

`default_nettype wire

// File: rtl/l2_reqs_table.sv
// Outstanding request table
`timescale 1ns/1ns
`default_nettype none

`include "l2_settings.svh"

module l2_reqs_table (
    input  wire                    clk,
    input  wire                    rst,
    input  wire                    alloc_i,
    input  wire l2_pkg::set_t      alloc_set_i,
    input  wire                    free_i,
    input  wire l2_pkg::reqs_idx_t free_idx_i,
    input  wire                    fwd_i,
    input  wire l2_pkg::set_t      fwd_set_i,
    output logic                   alloc_ok_o,
    output l2_pkg::reqs_idx_t      alloc_idx_o,
    output logic                   alloc_busy_o,
    output logic                   fwd_done_o,
    l2_regs_if.reqs                regs_if
);

    l2_pkg::req_entry_t entries [`N_REQS];
    l2_pkg::reqs_idx_t free_slot, alloc_hit_idx, fwd_hit_idx, conflict_idx, free_idx_q;
    logic found_free, alloc_hit, fwd_hit, alloc_refuse, alloc_go, free_q;

    // descending scan so the lowest matching index wins.
    always_comb begin
        found_free = 1'b0;
        free_slot = '0;
        alloc_hit = 1'b0;
        alloc_hit_idx = '0;
        fwd_hit = 1'b0;
        fwd_hit_idx = '0;
        for (int i = `N_REQS - 1; i >= 0; i--) begin
            if (!entries[i].valid) begin
                found_free = 1'b1;
                free_slot = l2_pkg::reqs_idx_t'(i);
            end
            if (entries[i].valid && entries[i].req_set == alloc_set_i) begin
                alloc_hit = 1'b1;
                alloc_hit_idx = l2_pkg::reqs_idx_t'(i);
            end
            if (entries[i].valid && entries[i].req_set == fwd_set_i) begin
                fwd_hit = 1'b1;
                fwd_hit_idx = l2_pkg::reqs_idx_t'(i);
            end
        end
    end

    assign alloc_refuse = regs_if.ongoing_flush || regs_if.set_conflict || !found_free;
    assign alloc_go = alloc_i && !alloc_refuse && !alloc_hit;

    assign regs_if.set_set_conflict = alloc_i && !alloc_refuse && alloc_hit;
    assign regs_if.clr_set_conflict = free_i && regs_if.set_conflict &&
                                      free_idx_i == conflict_idx;

    // a new forward is ignored while a stall is pending.
    assign regs_if.set_fwd_stall = fwd_i && fwd_hit && !regs_if.fwd_stall;
    assign regs_if.set_fwd_stall_i = regs_if.set_fwd_stall;
    assign regs_if.fwd_stall_i_wr_data = fwd_hit_idx;
    assign regs_if.clr_fwd_stall = regs_if.fwd_stall_ended;
    assign regs_if.clr_fwd_stall_ended = regs_if.fwd_stall_ended;
    assign fwd_done_o = regs_if.fwd_stall_ended;

    assign regs_if.fill_reqs = alloc_ok_o;     // count follows the grant.
    assign regs_if.incr_reqs_cnt = free_q;
    assign regs_if.wr_en_put_reqs = free_q;
    assign regs_if.reqs_i = free_idx_q;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int i = 0; i < `N_REQS; i++) begin
                entries[i] <= '0;
            end
            alloc_ok_o <= 1'b0;
            alloc_busy_o <= 1'b0;
            free_q <= 1'b0;
        end else begin
            if (free_i) begin
                entries[free_idx_i].valid <= 1'b0;
            end
            if (alloc_go) begin
                entries[free_slot] <= '{valid: 1'b1, req_set: alloc_set_i};
            end
            alloc_ok_o <= alloc_go;
            alloc_busy_o <= alloc_i && alloc_refuse;
            free_q <= free_i;
        end
    end

    always_ff @(posedge clk) begin
        alloc_idx_o <= free_slot;
        free_idx_q <= free_idx_i;
        if (regs_if.set_set_conflict) begin
            conflict_idx <= alloc_hit_idx;
        end
    end

    a_free_valid: assert property (@(posedge clk) disable iff (!rst)
        free_i |-> entries[free_idx_i].valid);

    // counter at zero with no free in flight means no slot is open.
    a_cnt_full: assert property (@(posedge clk) disable iff (!rst)
        (regs_if.reqs_cnt == '0) && !free_q |-> !found_free);

    a_stall_held: assert property (@(posedge clk) disable iff (!rst)
        regs_if.fwd_stall && !regs_if.fwd_stall_ended && !free_q
        |-> entries[regs_if.fwd_stall_i].valid);

endmodule

`default_nettype wire

// File: rtl/l2_settings.svh
// L2 slice sizes
`ifndef L2_SETTINGS_SVH
`define L2_SETTINGS_SVH

// set index width for 8 sets.
`define L2_SET_BITS 3

// way index width for 4 ways.
`define L2_WAY_BITS 2

// request table index width.
`define REQS_BITS 2

// number of request table entries.
`define N_REQS 4

// request counter width holding 0 up to N_REQS.
`define REQS_BITS_P1 3

`endif

// File: run.sh
#!/bin/sh
# build and run the L2 slice testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wall -Wno-fatal -f compile.f --top-module l2_tb
status=$?
if [ $status -ne 0 ]; then
    echo "compile step failed with status $status"
    exit 1
fi

output=$(./obj_dir/Vl2_tb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "ALL TESTS PASSED"; then
    exit 0
fi
exit 1

// File: testbench/l2_checker.sv
// L2 slice reference model and checks
`timescale 1ns/1ns
`default_nettype none

module l2_checker (
    input  wire        clk,
    input  wire        rst,
    input  wire        alloc_i,
    input  wire  [2:0] alloc_set_i,
    input  wire        free_i,
    input  wire  [1:0] free_idx_i,
    input  wire        fwd_i,
    input  wire  [2:0] fwd_set_i,
    input  wire        flush_i,
    input  wire        alloc_ok_o,
    input  wire  [1:0] alloc_idx_o,
    input  wire        alloc_busy_o,
    input  wire        conflict_o,
    input  wire        fwd_stall_o,
    input  wire        fwd_done_o,
    input  wire        ongoing_flush_o,
    input  wire  [2:0] reqs_cnt_o,
    input  wire        flush_valid_o,
    input  wire  [2:0] flush_set_o,
    input  wire  [1:0] flush_way_o,
    input  wire        flush_done_o,
    input  wire  [7:0] test_num_i,
    input  wire        test_end_i,
    input  wire        report_i,
    output int         err_cnt_o
);

    logic       m_valid [4];
    logic [2:0] m_set [4];
    int         m_cnt, m_fset, m_fway;
    logic       m_ok, m_busy, m_conf, m_stall, m_ended, m_free_q, m_flush, m_sweep;
    logic [1:0] m_idx, m_conf_idx, m_stall_idx, m_free_idx_q;
    logic [1:0] slot, ahit_idx, fhit_idx;
    logic       found, ahit, fhit, refuse, done, fvalid, n_ended;
    int         test_err, tests_run, tests_failed;

    function automatic string test_name(input logic [7:0] num);
        case (num)
            8'd1:    return "reset_state";
            8'd2:    return "alloc_free";
            8'd3:    return "set_conflict";
            8'd4:    return "fwd_stall";
            8'd5:    return "flush_sweep";
            default: return "unknown";
        endcase
    endfunction

    task automatic compare(input string sig, input int exp, input int act);
        if (exp != act) begin
            $display("[FAIL] %s %s expected %0d actual %0d",
                     test_name(test_num_i), sig, exp, act);
            err_cnt_o++;
            test_err++;
        end
    endtask

    initial begin
        err_cnt_o = 0;
        test_err = 0;
        tests_run = 0;
        tests_failed = 0;
    end

    // cycle model stepped on every rising edge.
    always @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int i = 0; i < 4; i++) begin
                m_valid[i] = 1'b0;
                m_set[i] = '0;
            end
            m_cnt = 4;
            {m_ok, m_busy, m_conf, m_stall, m_ended, m_free_q, m_flush, m_sweep} = '0;
            {m_idx, m_conf_idx, m_stall_idx, m_free_idx_q} = '0;
            m_fset = 0;
            m_fway = 0;
        end else begin
            found = 1'b0;
            ahit = 1'b0;
            fhit = 1'b0;
            slot = '0;
            ahit_idx = '0;
            fhit_idx = '0;
            for (int i = 3; i >= 0; i--) begin
                if (!m_valid[i]) begin
                    found = 1'b1;
                    slot = 2'(i);
                end
                if (m_valid[i] && m_set[i] == alloc_set_i) begin
                    ahit = 1'b1;
                    ahit_idx = 2'(i);
                end
                if (m_valid[i] && m_set[i] == fwd_set_i) begin
                    fhit = 1'b1;
                    fhit_idx = 2'(i);
                end
            end
            refuse = m_flush || m_conf || !found;
            done = m_flush && m_fset == 8;
            fvalid = m_sweep && m_fset != 8;
            m_cnt = m_cnt - int'(m_ok) + int'(m_free_q);
            n_ended = m_ended ? 1'b0 :
                      (m_free_q && m_stall && m_stall_idx == m_free_idx_q) ? 1'b1 : m_ended;
            if (m_ended) begin
                m_stall = 1'b0;
            end else if (fwd_i && fhit && !m_stall) begin
                m_stall = 1'b1;
                m_stall_idx = fhit_idx;
            end
            m_ended = n_ended;
            if (free_i && m_conf && free_idx_i == m_conf_idx) begin
                m_conf = 1'b0;
            end else if (alloc_i && !refuse && ahit) begin
                m_conf = 1'b1;
                m_conf_idx = ahit_idx;
            end
            m_ok = alloc_i && !refuse && !ahit;
            m_busy = alloc_i && refuse;
            m_idx = slot;
            if (free_i) m_valid[free_idx_i] = 1'b0;
            if (m_ok) begin
                m_valid[slot] = 1'b1;
                m_set[slot] = alloc_set_i;
            end
            m_free_q = free_i;
            m_free_idx_q = free_idx_i;
            m_sweep = m_flush && m_fset != 8;
            if (done) begin
                m_flush = 1'b0;
                m_fset = 0;
                m_fway = 0;
            end else begin
                if (flush_i && !m_flush) m_flush = 1'b1;
                if (fvalid && m_fway == 3) begin
                    m_fway = 0;
                    m_fset++;
                end else if (fvalid) begin
                    m_fway++;
                end
            end
        end
    end

    // outputs are settled at the falling edge.
    always @(negedge clk) begin
        if (rst) begin
            compare("alloc_ok_o", m_ok, alloc_ok_o);
            if (m_ok) compare("alloc_idx_o", m_idx, alloc_idx_o);
            compare("alloc_busy_o", m_busy, alloc_busy_o);
            compare("conflict_o", m_conf, conflict_o);
            compare("fwd_stall_o", m_stall, fwd_stall_o);
            compare("fwd_done_o", m_ended, fwd_done_o);
            compare("ongoing_flush_o", m_flush, ongoing_flush_o);
            compare("reqs_cnt_o", m_cnt, reqs_cnt_o);
            compare("flush_valid_o", m_sweep && m_fset != 8, flush_valid_o);
            compare("flush_done_o", m_flush && m_fset == 8, flush_done_o);
            if (flush_valid_o) begin
                compare("flush_set_o", m_fset, flush_set_o);
                compare("flush_way_o", m_fway, flush_way_o);
            end
        end
    end

    always @(posedge clk) begin
        if (test_end_i) begin
            $display("%s: %s", test_name(test_num_i), test_err == 0 ? "pass" : "fail");
            tests_run++;
            if (test_err != 0) tests_failed++;
            test_err = 0;
        end
        if (report_i) begin
            $display("tests run %0d, tests failed %0d, errors %0d",
                     tests_run, tests_failed, err_cnt_o);
        end
    end

endmodule

`default_nettype wire

// File: testbench/l2_tb.sv
// L2 slice testbench top
`timescale 1ns/1ns
`default_nettype none

module l2_tb;

    logic       clk, rst, alloc_i, free_i, fwd_i, flush_i;
    logic [2:0] alloc_set_i, fwd_set_i;
    logic [1:0] free_idx_i;
    logic       alloc_ok_o, alloc_busy_o, conflict_o, fwd_stall_o, fwd_done_o;
    logic       ongoing_flush_o, flush_valid_o, flush_done_o;
    logic [1:0] alloc_idx_o, flush_way_o;
    logic [2:0] reqs_cnt_o, flush_set_o;
    logic [7:0] test_num;
    logic       test_end, report;
    int         err_cnt;
    int         seed;
    logic       held [4];
    logic       used [8];

    tb_clk_gen u_clk (.clk_o(clk));

    l2_ctrl_top dut (.*);

    l2_checker u_checker (
        .test_num_i (test_num),
        .test_end_i (test_end),
        .report_i   (report),
        .err_cnt_o  (err_cnt),
        .*
    );

    task automatic tick();
        @(negedge clk);
    endtask

    function automatic logic probe(input int which);
        case (which)
            0:       return alloc_ok_o || alloc_busy_o || conflict_o;
            1:       return !conflict_o;
            2:       return fwd_stall_o;
            3:       return !fwd_stall_o;
            default: return flush_done_o;
        endcase
    endfunction

    task automatic wait_until(input int which);
        int n;
        n = 0;
        while (!probe(which) && n < 100) begin
            n++;
            tick();
        end
        if (!probe(which)) begin
            $display("timeout: condition %0d never came in test %0d", which, test_num);
            $display("SOME TESTS FAILED");
            $finish;
        end
    endtask

    task automatic alloc_req(input logic [2:0] s);
        alloc_i = 1'b1;
        alloc_set_i = s;
        tick();
        alloc_i = 1'b0;
        wait_until(0);
        if (alloc_ok_o) begin
            held[alloc_idx_o] = 1'b1;
            used[s] = 1'b1;
        end
        tick();
    endtask

    task automatic free_entry(input logic [1:0] idx);
        free_i = 1'b1;
        free_idx_i = idx;
        tick();
        free_i = 1'b0;
        held[idx] = 1'b0;
        tick();
    endtask

    task automatic send_fwd(input logic [2:0] s);
        fwd_i = 1'b1;
        fwd_set_i = s;
        tick();
        fwd_i = 1'b0;
    endtask

    task automatic finish_test();
        test_end = 1'b1;
        tick();
        test_end = 1'b0;
    endtask

    initial begin
        logic [2:0] s;
        logic [1:0] idx;
        seed = 70;
        {rst, alloc_i, free_i, fwd_i, flush_i, test_end, report} = '0;
        {alloc_set_i, fwd_set_i, free_idx_i} = '0;
        test_num = 8'd1;
        for (int i = 0; i < 8; i++) used[i] = 1'b0;
        for (int i = 0; i < 4; i++) held[i] = 1'b0;
        repeat (4) @(posedge clk);
        tick();
        rst = 1'b1;
        tick();
        finish_test();

        test_num = 8'd2;
        for (int k = 0; k < 5; k++) begin
            s = 3'($random(seed));
            for (int g = 0; g < 50 && used[s]; g++) s = 3'($random(seed));
            alloc_req(s); // the fifth one hits a full table.
        end
        for (int k = 0; k < 4; k++) begin
            idx = 2'($random(seed));
            for (int g = 0; g < 4 && !held[idx]; g++) idx = idx + 2'd1;
            free_entry(idx);
        end
        finish_test();

        test_num = 8'd3;
        alloc_req(3'd5);
        alloc_req(3'd5);
        alloc_req(3'd2);
        free_entry(2'd0);
        wait_until(1);
        finish_test();

        test_num = 8'd4;
        alloc_req(3'd1);
        alloc_req(3'd3);
        send_fwd(3'd3);
        wait_until(2);
        free_entry(2'd0);
        free_entry(2'd1);
        wait_until(3);
        send_fwd(3'd6);
        repeat (3) tick();
        finish_test();

        test_num = 8'd5;
        flush_i = 1'b1;
        tick();
        flush_i = 1'b0;
        alloc_req(3'd4);
        wait_until(4);
        repeat (3) tick();
        finish_test();

        report = 1'b1;
        tick();
        report = 1'b0;
        tick();
        if (err_cnt == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: testbench/tb_clk_gen.sv
// Testbench clock source
`timescale 1ns/1ns
`default_nettype none

module tb_clk_gen (
    output logic clk_o
);

    initial clk_o = 1'b0;

    always #20 clk_o = ~clk_o; // 40 ns period.

endmodule

`default_nettype wire
